// ==== dv/video_mem_chk.sv ====
// Bound assertions on the LCD fetcher covering address hold, row ordering and the Gray crossing
`timescale 1ns/1ps
`include "video_mem_config.svh"

module video_mem_chk (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [`VM_BUF_AW-1:0]       lcd_addr,
	input  logic                        lcd_wait,
	input  logic                        lcd_newfield,
	input  logic [10:0]                 lcd_row,
	input  video_pixel_pkg::vid_addr_t  hdmi_addr
);
	import video_pixel_pkg::*;

	function automatic logic [VID_ADDR_W-1:0] to_gray(input logic [VID_ADDR_W-1:0] b);
		return b ^ (b >> 1);
	endfunction

	// A held fetcher keeps its buffer address for the following cycle
	a_hold_on_wait: assert property (@(posedge clk) disable iff (reset)
		lcd_wait |=> $stable(lcd_addr))
		else $error("LCD address moved while lcd_wait was high");

	// Outside field wait the LCD never runs ahead of the row HDMI is showing
	a_row_behind: assert property (@(posedge clk) disable iff (reset)
		!lcd_newfield |-> (lcd_row <= hdmi_addr.row))
		else $error("LCD row passed the synchronized HDMI row");

	// A nonzero column only comes from a single pixel step
	// so the synchronized position moves by one Gray bit at most
	a_gray_step: assert property (@(posedge clk) disable iff (reset)
		(hdmi_addr.col != 9'd0) |->
			$onehot0(to_gray(hdmi_addr) ^ to_gray($past(hdmi_addr))))
		else $error("Synchronized HDMI address jumped by more than one Gray bit");

endmodule

// The fetcher sees both its own position and the synchronized HDMI position
bind lcd_fetch video_mem_chk u_chk (
	.clk          (clk),
	.reset        (reset),
	.lcd_addr     (lcd_addr),
	.lcd_wait     (lcd_wait),
	.lcd_newfield (lcd_newfield),
	.lcd_row      (pos.row),
	.hdmi_addr    (curr_vid_addr)
);

// ==== dv/video_mem_tb.sv ====
// Testbench for the video frame store with renderer, HDMI raster and LCD models
`timescale 1ns/1ps
`include "video_mem_config.svh"

module video_mem_tb;
	// Two fields of 525 by 800 pixel clocks expressed in clk cycles, plus margin
	localparam int LIMIT = 2 * 525 * 800 * 10 / 8 + 20000;
	localparam logic [31:0] SEED = 32'h74594bd4;

	logic clk = 1'b0;
	logic pixel_clk = 1'b0;
	logic reset, wen, ren, fetch_next, next_line, next_field;
	logic lcd_next_pixel = 1'b0;
	logic [19:0] addr, curr_vid_addr;
	logic [23:0] data_in, data_out;
	logic next_field_out, preload, lcd_newfield, lcd_wait;
	logic [7:0] lcd_red, lcd_green, lcd_blue, red, green, blue;
	logic [31:0] lcd_rnd = SEED;
	int cycles = 0;
	// HDMI scaler model state
	int h_row, h_col, h_xs, h_ys, h_skip, h_act, h_pre, h_pend, h_cmp, h_count;
	logic [19:0] h_pend_addr, h_cmp_addr;
	// LCD fetcher model state where 0 is field wait, 1 is run and 2 is line wait
	int l_st, l_row, l_col, l_fields, l_count, l_hit;
	logic [19:0] l_hit_addr;
	// Field strobe sampled on clk and carried through the three stages of the crossing
	logic [2:0] field_seen;

	always #4 clk = ~clk;
	always #5 pixel_clk = ~pixel_clk;

	video_mem u_dut (.*);

	// Galois LFSR step with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// Expected pixel at a source position, one LFSR step per output bit
	function automatic logic [23:0] pixel_ref(input int row, input int col);
		logic [31:0] s;
		logic [23:0] v;
		s = SEED ^ (row << 12) ^ col;
		for (int i = 0; i < 24; i++) begin
			v[i] = s[0];
			s = lfsr_step(s);
		end
		return v;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			$display("Test failures found");
			$fatal(1, "stopped at first error");
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > LIMIT) begin
			$display("Timeout: the run did not finish within %0d clk cycles", LIMIT);
			$display("Test failures found");
			$fatal(1, "stopped on timeout");
		end
	end

	// LCD requests come from two LFSR bits so three of four cycles ask for a pixel
	always @(posedge clk) begin
		if (reset) begin
			lcd_next_pixel <= 1'b0;
		end else begin
			lcd_next_pixel <= lcd_rnd[0] | lcd_rnd[1];
			lcd_rnd = lfsr_step(lfsr_step(lcd_rnd));
		end
	end

	// The field strobe reaches the system side three clk cycles after it is sampled
	always @(posedge clk) begin
		if (reset) begin
			field_seen = '0;
		end else begin
			field_seen = {field_seen[1:0], next_field};
		end
	end

	// HDMI scaler reference on the pixel clock using the pre-edge strobes
	always @(posedge pixel_clk) begin
		if (reset) begin
			{h_row, h_col, h_xs, h_ys, h_skip, h_act, h_pre, h_pend, h_cmp} = '0;
		end else begin
			h_cmp = h_pend;
			h_cmp_addr = h_pend_addr;
			h_pend = 0;
			if (next_field) begin
				{h_row, h_col, h_xs, h_ys, h_skip, h_act} = '0;
			end else if (next_line) begin
				h_col = 0;
				if (!h_act) begin
					if (h_skip == `VM_SKIP_LINES - `VM_PRELOAD_LEAD) h_pre = 1;
					if (h_skip == `VM_SKIP_LINES) h_act = 1;
					h_skip++;
				end else begin
					if (h_ys != 2 && h_row < `VM_LCD_H) h_row++;
					h_ys = (h_ys == 2) ? 0 : h_ys + 1;
				end
			end else if (fetch_next) begin
				if (h_xs != 3) begin
					h_col++;
					h_pre = 0;
				end
				h_xs = (h_xs + 1) % 4;
				// Only visible source pixels that the renderer has written are compared
				if (h_act && h_row < `VM_LCD_H && h_col < `VM_LCD_W) begin
					h_pend = 1;
					h_pend_addr = {h_row[10:0], h_col[8:0]};
				end
			end
		end
	end

	always @(negedge pixel_clk) begin
		if (!reset) begin
			check_value("preload", preload, h_pre);
			if (h_cmp) begin
				check_value("hdmi_rgb", {blue, green, red},
					pixel_ref(h_cmp_addr[19:9], h_cmp_addr[8:0]));
				h_count++;
			end
		end
	end

	// LCD fetcher reference on clk with its own row and column counters
	always @(posedge clk) begin
		l_hit = 0;
		if (reset) begin
			{l_st, l_col, l_fields, l_count} = '0;
			l_row = `VM_LCD_H;
		end else if (l_st == 0) begin
			if (curr_vid_addr == 20'd1) begin
				{l_st, l_row, l_col} = {32'd1, 32'd0, 32'd0};
			end
		end else if (l_col == `VM_LCD_W - 1 && l_row == curr_vid_addr[19:9]) begin
			l_st = 2;
		end else if (l_st == 2) begin
			l_st = 1;
		end else if (lcd_next_pixel) begin
			l_hit = 1;
			l_hit_addr = {l_row[10:0], l_col[8:0]};
			l_col++;
			if (l_col == `VM_LCD_W) begin
				l_col = 0;
				l_row++;
				if (l_row == `VM_LCD_H) begin
					l_st = 0;
					l_fields++;
				end
			end
		end
	end

	always @(negedge clk) begin
		if (!reset) begin
			check_value("lcd_wait", lcd_wait, (l_st != 1) ||
				(l_col == `VM_LCD_W - 1 && l_row == curr_vid_addr[19:9]));
			check_value("lcd_newfield", lcd_newfield, l_st == 0);
			check_value("next_field_out", next_field_out, field_seen[2]);
			if (l_hit) begin
				check_value("lcd_rgb", {lcd_blue, lcd_green, lcd_red},
					pixel_ref(l_hit_addr[19:9], l_hit_addr[8:0]));
				l_count++;
			end
			// HDMI stays on row zero through the overscan lines
			if (!h_act && h_skip >= 1) check_value("curr_vid_addr.row", curr_vid_addr[19:9], 0);
		end
	end

	task automatic readback_test();
		for (int i = 0; i < 4; i++) begin
			@(posedge clk);
			addr <= {11'(5 + i), 9'(7 * i + 3)};
			data_in <= pixel_ref(5 + i, 7 * i + 3);
			wen <= 1'b1;
			@(posedge clk);
			wen <= 1'b0;
			ren <= 1'b1;
			@(posedge clk);
			ren <= 1'b0;
			@(negedge clk);
			check_value("data_out", data_out, pixel_ref(5 + i, 7 * i + 3));
		end
	endtask

	// Renderer keeps two rows ahead of HDMI and restarts on each field strobe
	task automatic render_forever();
		int wr_row = 0;
		int wr_col = 0;
		logic seen = 1'b0;
		forever begin
			@(posedge clk);
			if (next_field_out && !seen) begin
				wr_row = 0;
				wr_col = 0;
			end
			seen = next_field_out;
			if (wr_row < `VM_LCD_H && wr_row <= curr_vid_addr[19:9] + 2) begin
				addr <= {wr_row[10:0], wr_col[8:0]};
				data_in <= pixel_ref(wr_row, wr_col);
				wen <= 1'b1;
				wr_col++;
				if (wr_col == `VM_LCD_W) begin
					wr_col = 0;
					wr_row++;
				end
			end else begin
				wen <= 1'b0;
			end
		end
	endtask

	// One raster field of 525 lines with 159 blank pixels, 640 fetches and a line strobe
	task automatic hdmi_field();
		@(posedge pixel_clk);
		next_field <= 1'b1;
		@(posedge pixel_clk);
		next_field <= 1'b0;
		for (int ln = 0; ln < 525; ln++) begin
			repeat (159) @(posedge pixel_clk);
			for (int px = 0; px < 640; px++) begin
				fetch_next <= 1'b1;
				@(posedge pixel_clk);
			end
			fetch_next <= 1'b0;
			if (ln < 524) begin
				next_line <= 1'b1;
				@(posedge pixel_clk);
				next_line <= 1'b0;
			end
		end
	endtask

	initial begin
		reset = 1'b1;
		{wen, ren, fetch_next, next_line, next_field} = '0;
		addr = '0;
		data_in = '0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		readback_test();
		fork
			begin
				hdmi_field();
				hdmi_field();
			end
			render_forever();
		join_any
		disable fork;
		if (l_fields < 1 || h_count == 0 || l_count == 0) begin
			$display("Too little traffic: the LCD did not complete a field or nothing was compared");
			$display("Test failures found");
			$fatal(1, "stopped on missing traffic");
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

// ==== verilog/hdmi_scan_addr.sv ====
// HDMI scan address generator that scales the 480x320 source to a 640x480 raster on the pixel clock
`timescale 1ns/1ps
`include "video_mem_config.svh"

module hdmi_scan_addr (
	input  logic                          pixel_clk,
	input  logic                          reset,
	input  logic                          fetch_next,
	input  logic                          next_line,
	input  logic                          next_field,
	output video_pixel_pkg::vid_addr_t    scan_addr,
	output logic [`VM_BUF_AW-1:0]         scan_buf_addr,
	output logic                          preload
);
	import video_pixel_pkg::*;
	import video_ctrl_pkg::*;

	// Wide enough to count one past the last overscan line
	localparam int SKIP_W = $clog2(`VM_SKIP_LINES + 2);

	vid_addr_t          addr;
	vid_addr_t          nxt_addr;
	logic [VID_ADDR_W-1:0] nxt_bin;
	scan_state_e        state;
	scan_state_e        nxt_state;
	logic [1:0]         x_skip;
	logic [1:0]         nxt_x_skip;
	logic [1:0]         y_skip;
	logic [1:0]         nxt_y_skip;
	logic [SKIP_W-1:0]  skip_lines;
	logic [SKIP_W-1:0]  nxt_skip_lines;
	logic               nxt_preload;

	// Next-state logic
	// Field strobe wins over line strobe which wins over pixel fetch
	always_comb begin
		nxt_addr       = addr;
		nxt_state      = state;
		nxt_x_skip     = x_skip;
		nxt_y_skip     = y_skip;
		nxt_skip_lines = skip_lines;
		nxt_preload    = preload;
		if (next_field) begin
			// The field strobe arrives at the end of visible space
			nxt_addr       = '0;
			nxt_x_skip     = '0;
			nxt_y_skip     = '0;
			nxt_skip_lines = '0;
			nxt_state      = SCAN_OVERSCAN;
		end else if (next_line) begin
			// Column restarts on every line, overscan included, so it never spills into the row
			nxt_addr.col = '0;
			if (state == SCAN_OVERSCAN) begin
				nxt_skip_lines = skip_lines + 1'b1;
				// Give the renderer a head start a few lines before the picture begins
				if (skip_lines == SKIP_W'(`VM_SKIP_LINES - `VM_PRELOAD_LEAD)) begin
					nxt_preload = 1'b1;
				end
				if (skip_lines == SKIP_W'(`VM_SKIP_LINES)) begin
					nxt_state = SCAN_ACTIVE;
				end
			end else begin
				// Two source rows span three raster lines so every third line repeats
				nxt_y_skip = (y_skip == 2'd2) ? 2'd0 : y_skip + 2'd1;
				if (y_skip != 2'd2 && addr.row < 11'(`VM_LCD_H)) begin
					nxt_addr.row = addr.row + 1'b1;
				end
			end
		end else if (fetch_next) begin
			// Three source pixels span four raster pixels so every fourth one repeats
			nxt_x_skip = x_skip + 2'd1;
			if (x_skip != 2'd3) begin
				nxt_addr.col = addr.col + 1'b1;
				nxt_preload  = 1'b0;
			end
		end
		nxt_bin = nxt_addr;
	end

	always_ff @(posedge pixel_clk) begin
		if (reset) begin
			addr       <= '0;
			scan_addr  <= '0;
			state      <= SCAN_OVERSCAN;
			x_skip     <= '0;
			y_skip     <= '0;
			skip_lines <= '0;
			preload    <= 1'b0;
		end else begin
			addr       <= nxt_addr;
			// Gray copy is registered so the crossing never sees combinational glitches
			scan_addr  <= nxt_bin ^ (nxt_bin >> 1);
			state      <= nxt_state;
			x_skip     <= nxt_x_skip;
			y_skip     <= nxt_y_skip;
			skip_lines <= nxt_skip_lines;
			preload    <= nxt_preload;
		end
	end

	// Buffer index is the binary column plus the low row bits
	assign scan_buf_addr = addr[`VM_BUF_AW-1:0];

endmodule

// ==== verilog/lcd_fetch.sv ====
// LCD address walker on the system clock that streams the native frame and stays behind the HDMI row
`timescale 1ns/1ps
`include "video_mem_config.svh"

module lcd_fetch (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        lcd_next_pixel,
	input  video_pixel_pkg::vid_addr_t  curr_vid_addr,
	output logic [`VM_BUF_AW-1:0]       lcd_addr,
	output logic                        lcd_newfield,
	output logic                        lcd_wait
);
	import video_pixel_pkg::*;
	import video_ctrl_pkg::*;

	vid_addr_t  pos;
	lcd_state_e state;
	logic       at_limit;
	logic       last_col;

	assign last_col = (pos.col == 9'(`VM_LCD_W - 1));

	// One more pixel here would step onto a row that HDMI has not finished with
	assign at_limit = last_col && (pos.row == curr_vid_addr.row);

	// Hold is seen in the same cycle so a pixel request is never taken at the limit
	assign lcd_wait     = (state != LCD_RUN) || at_limit;
	assign lcd_newfield = (state == LCD_FIELD_WAIT);
	assign lcd_addr     = pos[`VM_BUF_AW-1:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			// Park one row past the frame until the next field begins
			pos.row <= 11'(`VM_LCD_H);
			pos.col <= '0;
			state   <= LCD_FIELD_WAIT;
		end else begin
			case (state)
				LCD_FIELD_WAIT: begin
					// HDMI sits at address zero for the whole blanking gap
					// so the first fetch of the new field is what releases us
					if (curr_vid_addr == vid_addr_t'(1)) begin
						pos   <= '0;
						state <= LCD_RUN;
					end
				end
				LCD_RUN: begin
					if (at_limit) begin
						state <= LCD_LINE_WAIT;
					end else if (lcd_next_pixel) begin
						if (!last_col) begin
							pos.col <= pos.col + 1'b1;
						end else if (pos.row == 11'(`VM_LCD_H - 1)) begin
							pos.row <= 11'(`VM_LCD_H);
							pos.col <= '0;
							state   <= LCD_FIELD_WAIT;
						end else begin
							pos.row <= pos.row + 1'b1;
							pos.col <= '0;
						end
					end
				end
				LCD_LINE_WAIT: begin
					// Resume as soon as HDMI has moved on to a later row
					if (!at_limit) begin
						state <= LCD_RUN;
					end
				end
				default: begin
					state <= LCD_FIELD_WAIT;
				end
			endcase
		end
	end

endmodule

// ==== verilog/line_buffer_ram.sv ====
// Dual-clock 24x2048 line buffer with a renderer write and read-back port and a registered scan read port
`timescale 1ns/1ps
`include "video_mem_config.svh"

module line_buffer_ram #(
	// Set on the one copy that answers renderer read-back requests
	parameter bit READBACK = 1'b1
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        rd_clk,
	render_port_if.store                port,
	input  logic [`VM_BUF_AW-1:0]       rd_addr,
	output video_pixel_pkg::pixel_t     rd_data
);
	import video_pixel_pkg::*;

	pixel_t mem [0:`VM_BUF_DEPTH-1];

	// Only the low address bits index the ring
	// These are the full column plus the two low row bits so four rows fit
	always_ff @(posedge clk) begin
		if (port.wen) begin
			mem[port.addr[`VM_BUF_AW-1:0]] <= port.wdata;
		end
	end

	// Read port for the display side, clocked by whichever domain scans this copy
	always_ff @(posedge rd_clk) begin
		if (reset) begin
			rd_data <= '0;
		end else begin
			rd_data <= mem[rd_addr];
		end
	end

	// Read-back to the renderer lives on the write clock
	// The second copy leaves rdata alone so the shared bundle has a single driver
	if (READBACK) begin : g_readback
		always_ff @(posedge clk) begin
			if (reset) begin
				port.rdata <= '0;
			end else if (port.ren) begin
				port.rdata <= mem[port.addr[`VM_BUF_AW-1:0]];
			end
		end
	end

endmodule

// ==== verilog/render_port_if.sv ====
// Renderer port bundle carrying pixel writes and read-back between the top level and a line buffer
`timescale 1ns/1ps

interface render_port_if;
	import video_pixel_pkg::*;

	// Row and column of the pixel being written or read back
	vid_addr_t addr;
	// Pixel to store on a write
	pixel_t    wdata;
	// Write strobe sampled on clk
	logic      wen;
	// Read-back strobe sampled on clk
	logic      ren;
	// Read-back word valid one clk cycle after ren
	pixel_t    rdata;

	// Renderer side drives the request and takes the returned word
	modport render (
		output addr,
		output wdata,
		output wen,
		output ren,
		input  rdata
	);

	// Memory side takes the request and returns the stored word
	modport store (
		input  addr,
		input  wdata,
		input  wen,
		input  ren,
		output rdata
	);

endinterface

// ==== verilog/scan_pos_sync.sv ====
// Clock crossing of the Gray-coded HDMI scan position and the field strobe into the system clock
`timescale 1ns/1ps

module scan_pos_sync (
	input  logic                        clk,
	input  logic                        reset,
	input  video_pixel_pkg::vid_addr_t  scan_addr_gray,
	input  logic                        field_in,
	output video_pixel_pkg::vid_addr_t  curr_vid_addr,
	output logic                        next_field_out
);
	import video_pixel_pkg::*;

	vid_addr_t             gray_meta;
	vid_addr_t             gray_sync;
	logic [VID_ADDR_W-1:0] bin;
	logic                  field_meta;
	logic                  field_sync;

	// Gray back to binary
	// Each bit is the running XOR of all Gray bits above and including it
	always_comb begin
		bin[VID_ADDR_W-1] = gray_sync[VID_ADDR_W-1];
		for (int i = VID_ADDR_W - 2; i >= 0; i--) begin
			bin[i] = bin[i + 1] ^ gray_sync[i];
		end
	end

	// Two flops per signal take care of metastability
	// A pixel step flips one Gray bit so a late sample only lags by one position
	// The output register adds the third cycle and keeps the decoder off the port
	always_ff @(posedge clk) begin
		if (reset) begin
			gray_meta      <= '0;
			gray_sync      <= '0;
			curr_vid_addr  <= '0;
			field_meta     <= 1'b0;
			field_sync     <= 1'b0;
			next_field_out <= 1'b0;
		end else begin
			gray_meta      <= scan_addr_gray;
			gray_sync      <= gray_meta;
			curr_vid_addr  <= bin;
			// Field strobe gets the same depth so it lines up with the address
			field_meta     <= field_in;
			field_sync     <= field_meta;
			next_field_out <= field_sync;
		end
	end

	// A pixel clock strobe lasts longer than a system clock period
	// so the field pulse is always seen at least once

endmodule

// ==== verilog/video_ctrl_pkg.sv ====
// Control state types for the LCD address walker and the HDMI scan address generator
package video_ctrl_pkg;

	// LCD fetcher states
	// Field wait holds the walker parked on the row just past the frame
	// Line wait holds it at the end of the row that HDMI is still showing
	typedef enum logic [1:0] {
		LCD_FIELD_WAIT = 2'd0,
		LCD_RUN        = 2'd1,
		LCD_LINE_WAIT  = 2'd2
	} lcd_state_e;

	// HDMI scan states
	// Overscan covers the blank lines after the field strobe where the row stays at zero
	// Active is the visible part where lines are repeated to scale 320 rows to 480
	typedef enum logic {
		SCAN_OVERSCAN = 1'b0,
		SCAN_ACTIVE   = 1'b1
	} scan_state_e;

endpackage

// ==== verilog/video_mem.sv ====
// Video frame store top level joining the renderer port, both line buffers, the HDMI scaler and the LCD fetcher
`timescale 1ns/1ps
`include "video_mem_config.svh"

module video_mem (
	input  logic                        clk,
	input  logic                        pixel_clk,
	input  logic                        reset,

	// Renderer side
	input  video_pixel_pkg::vid_addr_t  addr,
	input  video_pixel_pkg::pixel_t     data_in,
	input  logic                        wen,
	input  logic                        ren,
	output video_pixel_pkg::pixel_t     data_out,
	output video_pixel_pkg::vid_addr_t  curr_vid_addr,
	output logic                        next_field_out,
	output logic                        preload,

	// LCD side
	input  logic                        lcd_next_pixel,
	output logic                        lcd_newfield,
	output logic                        lcd_wait,
	output logic [7:0]                  lcd_red,
	output logic [7:0]                  lcd_green,
	output logic [7:0]                  lcd_blue,

	// HDMI side on the pixel clock
	input  logic                        fetch_next,
	input  logic                        next_line,
	input  logic                        next_field,
	output logic [7:0]                  red,
	output logic [7:0]                  green,
	output logic [7:0]                  blue
);
	import video_pixel_pkg::*;

	vid_addr_t              hdmi_gray;
	logic [`VM_BUF_AW-1:0]  hdmi_buf_addr;
	logic [`VM_BUF_AW-1:0]  lcd_buf_addr;
	pixel_t                 hdmi_pix;
	pixel_t                 lcd_pix;

	// The top level plays the renderer end of the bundle
	render_port_if u_render_port ();

	assign u_render_port.addr  = addr;
	assign u_render_port.wdata = data_in;
	assign u_render_port.wen   = wen;
	assign u_render_port.ren   = ren;
	assign data_out            = u_render_port.rdata;

	// Both copies take every write so each display gets a private read port
	// HDMI copy also serves renderer read-back
	line_buffer_ram #(.READBACK(1'b1)) u_ram_hdmi (
		.clk     (clk),
		.reset   (reset),
		.rd_clk  (pixel_clk),
		.port    (u_render_port),
		.rd_addr (hdmi_buf_addr),
		.rd_data (hdmi_pix)
	);

	line_buffer_ram #(.READBACK(1'b0)) u_ram_lcd (
		.clk     (clk),
		.reset   (reset),
		.rd_clk  (clk),
		.port    (u_render_port),
		.rd_addr (lcd_buf_addr),
		.rd_data (lcd_pix)
	);

	hdmi_scan_addr u_hdmi_scan_addr (
		.pixel_clk     (pixel_clk),
		.reset         (reset),
		.fetch_next    (fetch_next),
		.next_line     (next_line),
		.next_field    (next_field),
		.scan_addr     (hdmi_gray),
		.scan_buf_addr (hdmi_buf_addr),
		.preload       (preload)
	);

	scan_pos_sync u_scan_pos_sync (
		.clk            (clk),
		.reset          (reset),
		.scan_addr_gray (hdmi_gray),
		.field_in       (next_field),
		.curr_vid_addr  (curr_vid_addr),
		.next_field_out (next_field_out)
	);

	lcd_fetch u_lcd_fetch (
		.clk            (clk),
		.reset          (reset),
		.lcd_next_pixel (lcd_next_pixel),
		.curr_vid_addr  (curr_vid_addr),
		.lcd_addr       (lcd_buf_addr),
		.lcd_newfield   (lcd_newfield),
		.lcd_wait       (lcd_wait)
	);

	assign red       = hdmi_pix.red;
	assign green     = hdmi_pix.green;
	assign blue      = hdmi_pix.blue;
	assign lcd_red   = lcd_pix.red;
	assign lcd_green = lcd_pix.green;
	assign lcd_blue  = lcd_pix.blue;

endmodule

// ==== verilog/video_mem_config.svh ====
// Video frame store configuration with display geometry, overscan timing and line buffer sizing
`ifndef VIDEO_MEM_CONFIG_SVH
`define VIDEO_MEM_CONFIG_SVH

// Native source frame as rendered and as shown on the LCD
`define VM_LCD_W 480
`define VM_LCD_H 320

// Overscan lines at the top of each HDMI field before rows start to advance
// The scaler skips one more line than this count
`define VM_SKIP_LINES 42

// Number of lines before the end of overscan at which the renderer is asked to start
`define VM_PRELOAD_LEAD 6

// Line buffer address width
// Column takes 9 bits and the low two row bits select one of four rows in the ring
`define VM_BUF_AW 11

// Line buffer depth in pixels
`define VM_BUF_DEPTH (1 << `VM_BUF_AW)

`endif

// ==== verilog/video_pixel_pkg.sv ====
// Pixel and video address types shared by the frame store, its ports and its address generators
package video_pixel_pkg;

	// One 24-bit pixel word as it sits in the line buffer
	// Red occupies the low byte so the word matches the renderer's RGB packing
	typedef struct packed {
		logic [7:0] blue;
		logic [7:0] green;
		logic [7:0] red;
	} pixel_t;

	// Video position as a single 20-bit word
	// Row sits in the upper 11 bits and column in the lower 9 bits
	// Since a row never holds more than 512 columns the word can be incremented
	// as a plain counter while walking along a line
	typedef struct packed {
		logic [10:0] row;
		logic [8:0]  col;
	} vid_addr_t;

	// Width of the flattened address word
	// Used when the position is treated as a vector for Gray conversion
	localparam int VID_ADDR_W = $bits(vid_addr_t);

endpackage

// ==== video_mem.f ====
+incdir+verilog
verilog/video_pixel_pkg.sv
verilog/video_ctrl_pkg.sv
verilog/render_port_if.sv
verilog/line_buffer_ram.sv
verilog/hdmi_scan_addr.sv
verilog/scan_pos_sync.sv
verilog/lcd_fetch.sv
verilog/video_mem.sv
dv/video_mem_chk.sv
dv/video_mem_tb.sv
